/* all.f */
rtl/axi_rd_pkg.sv
rtl/rr_pointer_arbiter.sv
rtl/ost_slot_table.sv
rtl/ar_pattern_table.sv
rtl/axi_rd_traffic_gen.sv
tests/axi_rd_slave_model.sv
tests/tb_axi_rd_traffic_gen.sv

/* Makefile */
# Verilator build and run for the AXI read traffic generator

VERILATOR ?= verilator
TOP       ?= tb_axi_rd_traffic_gen
RTL_TOP   ?= axi_rd_traffic_gen
FLAGS     ?= --assert
FILE_LIST ?= all.f
OBJ_DIR   ?= obj_dir

SOURCES   := $(shell cat $(FILE_LIST))
RTL_FILES := $(filter rtl/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) \
		-f $(FILE_LIST) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall $(FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_axi_rd_traffic_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_rd_traffic_gen;

    localparam int OST_DEPTH      = 12;
    localparam int MAX_REQ_NUM    = 32;
    localparam int RUN_BURSTS     = 48;
    localparam int TIMEOUT_CYCLES = RUN_BURSTS * 125;   // Far above ~10 cycles per burst
    localparam int ID_W           = axi_rd_pkg::axi_id_w;
    localparam int ADDR_W         = axi_rd_pkg::axi_addr_w;
    localparam int LEN_W          = axi_rd_pkg::axi_len_w;
    localparam int ID_N           = 1 << ID_W;

    // AR fields by pattern index, pattern 7 address accumulates per issue
    localparam logic [ADDR_W-1:0] PAT_ADDR [8] = '{
        32'h00, 32'h10, 32'h20, 32'h30, 32'h34, 32'h38, 32'h40, 32'h00
    };
    localparam axi_rd_pkg::axi_burst_e PAT_BURST [8] = '{
        axi_rd_pkg::burst_incr, axi_rd_pkg::burst_incr, axi_rd_pkg::burst_incr,
        axi_rd_pkg::burst_fixed, axi_rd_pkg::burst_wrap, axi_rd_pkg::burst_wrap,
        axi_rd_pkg::burst_fixed, axi_rd_pkg::burst_incr
    };
    localparam int PAT_BEATS [8] = '{4, 8, 8, 4, 4, 8, 8, 4};

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic                              ar_hold;
    logic [ID_W-1:0]                   arid;
    logic [ADDR_W-1:0]                 araddr;
    logic [LEN_W-1:0]                  arlen;
    axi_rd_pkg::axi_size_e             arsize;
    axi_rd_pkg::axi_burst_e            arburst;
    logic                              arvalid;
    logic                              arready;
    logic [ID_W-1:0]                   rid;
    logic [axi_rd_pkg::axi_data_w-1:0] rdata;
    logic                              rlast;
    logic                              rvalid;
    logic                              rready;
    logic                              req_finish;

    // Scoreboard
    bit [ID_N-1:0]          outstanding;
    int                     issue_cnt [ID_N];
    int                     issue_order [$];
    int                     out_cnt;
    int                     done_total;
    int                     cycles;
    bit                     saw_reorder;
    bit                     first_live = 1'b1;
    bit                     hold_prev;
    logic [ID_W-1:0]        arid_q;
    logic [ADDR_W-1:0]      araddr_q;
    logic [LEN_W-1:0]       arlen_q;
    axi_rd_pkg::axi_size_e  arsize_q;
    axi_rd_pkg::axi_burst_e arburst_q;

    always #4 clk = ~clk;

    axi_rd_traffic_gen #(
        .OST_DEPTH   (OST_DEPTH),
        .MAX_REQ_NUM (MAX_REQ_NUM)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .arid        (arid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .arvalid     (arvalid),
        .arready     (arready),
        .rid         (rid),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready),
        .req_finish  (req_finish)
    );

    axi_rd_slave_model u_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar_hold (ar_hold),
        .arid    (arid),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    task automatic report_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Expected AR fields for one pattern; n_prior is earlier issues of this ID
    task automatic expect_ar(input logic [2:0] pat, input int n_prior,
                             output logic [ADDR_W-1:0] addr,
                             output axi_rd_pkg::axi_burst_e burst, output int beats);
        addr  = PAT_ADDR[pat];
        burst = PAT_BURST[pat];
        beats = PAT_BEATS[pat];
        if (pat == 3'd7) begin
            addr = ADDR_W'(n_prior + 1) * axi_rd_pkg::wrap_step;   // Steps before issue
        end
    endtask

    // --------------------------------------------------
    // Monitor, sampled at the falling edge
    // --------------------------------------------------
    always @(negedge clk) begin
        logic [ADDR_W-1:0]      exp_addr;
        axi_rd_pkg::axi_burst_e exp_burst;
        int                     exp_beats;
        int                     pos;
        if (!rst_n) begin
            assert (!arvalid && !req_finish)
                else report_error("arvalid or req_finish high during reset");
            first_live = 1'b1;
            hold_prev  = 1'b0;
        end else begin
            if (first_live) begin
                assert (!arvalid) else report_error("arvalid high on first cycle after reset");
                first_live = 1'b0;
            end
            assert (rready) else report_error("rready low outside reset");
            if (hold_prev) begin
                assert (arvalid && (arid == arid_q) && (araddr == araddr_q)
                        && (arlen == arlen_q) && (arsize == arsize_q)
                        && (arburst == arburst_q))
                    else report_error("AR channel changed while stalled by arready");
            end
            hold_prev = arvalid && !arready;
            arid_q    = arid;
            araddr_q  = araddr;
            arlen_q   = arlen;
            arsize_q  = arsize;
            arburst_q = arburst;

            assert (req_finish == (done_total >= MAX_REQ_NUM))
                else report_error($sformatf("req_finish %0b after %0d completions",
                                            req_finish, done_total));

            if (rvalid && rready && rlast) begin
                if ((issue_order.size() > 0) && (issue_order[0] != int'(rid))) begin
                    saw_reorder = 1'b1;         // Not the oldest burst
                end
                pos = -1;
                for (int i = 0; i < issue_order.size(); i++) begin
                    if (issue_order[i] == int'(rid)) begin
                        pos = i;
                    end
                end
                if (pos >= 0) begin
                    issue_order.delete(pos);
                end
                outstanding[rid] = 1'b0;
                out_cnt--;
                done_total++;
            end

            if (arvalid && arready) begin
                expect_ar(arid[2:0], issue_cnt[arid], exp_addr, exp_burst, exp_beats);
                assert ((araddr == exp_addr) && (arburst == exp_burst)
                        && (arlen == LEN_W'(exp_beats - 1))
                        && (arsize == axi_rd_pkg::size_4_byte))
                    else report_error($sformatf(
                        "ARID %0d addr %h len %0d burst %0d, expected addr %h len %0d burst %0d",
                        arid, araddr, arlen, arburst, exp_addr, exp_beats - 1, exp_burst));
                assert (!outstanding[arid])
                    else report_error($sformatf("ARID %0d reissued while outstanding", arid));
                outstanding[arid] = 1'b1;
                issue_cnt[arid]++;
                issue_order.push_back(int'(arid));
                out_cnt++;
                assert (out_cnt <= OST_DEPTH)
                    else report_error($sformatf("%0d reads outstanding", out_cnt));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d bursts completed",
                     cycles, done_total, RUN_BURSTS);
            $display("Simulation FAILED");
            $fatal(1, "run did not complete in time");
        end
    end

    // --------------------------------------------------
    // Reset, run, drain
    // --------------------------------------------------
    initial begin
        rst_n   = 1'b0;
        ar_hold = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        wait (done_total >= RUN_BURSTS);
        @(negedge clk);
        ar_hold = 1'b1;                         // Stop new AR, let the rest finish
        repeat (4) @(posedge clk);
        wait (out_cnt == 0);
        if (saw_reorder) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_error("every burst completed in issue order");
        end
    end

endmodule

`default_nettype wire

/* tests/axi_rd_slave_model.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_rd_slave_model (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ar_hold,    // Forces arready low
    input  logic [axi_rd_pkg::axi_id_w-1:0]     arid,
    input  logic [axi_rd_pkg::axi_len_w-1:0]    arlen,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [axi_rd_pkg::axi_id_w-1:0]     rid,
    output logic [axi_rd_pkg::axi_data_w-1:0]   rdata,
    output logic                                rlast,
    output logic                                rvalid,
    input  logic                                rready
);

    localparam int ID_W   = axi_rd_pkg::axi_id_w;
    localparam int LEN_W  = axi_rd_pkg::axi_len_w;
    localparam int DATA_W = axi_rd_pkg::axi_data_w;

    logic [31:0]      lfsr = 32'h6512_4c4e;
    int               pend_id [$];          // Accepted bursts not yet started
    int               pend_beats [$];
    bit               active;
    int               cur_id;
    int               beats_left;           // Includes the beat on the bus
    int               beat_no;
    logic             live;
    logic             ar_hit;
    logic             r_hit;
    logic [ID_W-1:0]  hit_id;
    logic [LEN_W-1:0] hit_len;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // --------------------------------------------------
    // Sample on the falling edge, drive just after rise
    // --------------------------------------------------
    initial begin
        int pick;
        int coin;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rid     = '0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            live    = rst_n;
            ar_hit  = arvalid && arready;
            r_hit   = rvalid && rready;
            hit_id  = arid;
            hit_len = arlen;
            @(posedge clk);
            #1;
            if (!live) begin
                pend_id.delete();
                pend_beats.delete();
                active  = 1'b0;
                arready = 1'b0;
                rvalid  = 1'b0;
                rlast   = 1'b0;
            end else begin
                if (ar_hit) begin
                    pend_id.push_back(int'(hit_id));
                    pend_beats.push_back(int'(hit_len) + 1);
                end
                if (r_hit) begin
                    beats_left--;
                    beat_no++;
                    if (beats_left == 0) begin
                        active = 1'b0;
                    end
                end
                // Any pending burst may go next, so responses reorder
                if (!active && (pend_id.size() > 0)) begin
                    take_bits(4, pick);
                    pick       = pick % pend_id.size();
                    cur_id     = pend_id[pick];
                    beats_left = pend_beats[pick];
                    beat_no    = 0;
                    pend_id.delete(pick);
                    pend_beats.delete(pick);
                    active = 1'b1;
                end
                take_bits(2, coin);
                arready = !ar_hold && (coin != 0);      // Ready 3 cycles in 4
                take_bits(2, coin);
                rvalid = active && (coin != 0);         // Random gaps between beats
                rlast  = active && (beats_left == 1);
                rid    = ID_W'(cur_id);
                rdata  = (DATA_W'(cur_id) << 24) | DATA_W'(beat_no);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/axi_rd_traffic_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_rd_traffic_gen #(
    parameter int OST_DEPTH   = 16,     // Slots, 2 to 16
    parameter int MAX_REQ_NUM = 32      // Completions before req_finish
) (
    input  logic                                clk,
    input  logic                                rst_n,

    // AR channel
    output logic [axi_rd_pkg::axi_id_w-1:0]     arid,
    output logic [axi_rd_pkg::axi_addr_w-1:0]   araddr,
    output logic [axi_rd_pkg::axi_len_w-1:0]    arlen,
    output axi_rd_pkg::axi_size_e               arsize,
    output axi_rd_pkg::axi_burst_e              arburst,
    output logic                                arvalid,
    input  logic                                arready,

    // R channel
    input  logic [axi_rd_pkg::axi_id_w-1:0]     rid,
    input  logic                                rlast,
    input  logic                                rvalid,
    output logic                                rready,

    output logic                                req_finish
);

    localparam int PTR_W = $clog2(OST_DEPTH);

    logic             fill_en;
    logic [PTR_W-1:0] fill_slot;
    logic [PTR_W-1:0] issue_slot;

    // --------------------------------------------------
    // Slot control and AR field storage
    // --------------------------------------------------
    ost_slot_table #(
        .OST_DEPTH   (OST_DEPTH),
        .MAX_REQ_NUM (MAX_REQ_NUM)
    ) u_slot_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .arready     (arready),
        .rvalid      (rvalid),
        .rlast       (rlast),
        .rid         (rid),
        .arvalid     (arvalid),
        .fill_en     (fill_en),
        .fill_slot   (fill_slot),
        .issue_slot  (issue_slot),
        .req_finish  (req_finish)
    );

    ar_pattern_table #(
        .OST_DEPTH   (OST_DEPTH)
    ) u_pattern_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .fill_en     (fill_en),
        .fill_slot   (fill_slot),
        .issue_slot  (issue_slot),
        .arid        (arid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst)
    );

    assign rready = 1'b1;       // Read data is always accepted

endmodule

`default_nettype wire

/* rtl/ar_pattern_table.sv */
`timescale 1ns/10ps
`default_nettype none

module ar_pattern_table #(
    parameter int OST_DEPTH = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                fill_en,
    input  logic [$clog2(OST_DEPTH)-1:0]        fill_slot,
    input  logic [$clog2(OST_DEPTH)-1:0]        issue_slot,
    output logic [axi_rd_pkg::axi_id_w-1:0]     arid,
    output logic [axi_rd_pkg::axi_addr_w-1:0]   araddr,
    output logic [axi_rd_pkg::axi_len_w-1:0]    arlen,
    output axi_rd_pkg::axi_size_e               arsize,
    output axi_rd_pkg::axi_burst_e              arburst
);

    localparam int PTR_W  = $clog2(OST_DEPTH);
    localparam int ID_W   = axi_rd_pkg::axi_id_w;
    localparam int ADDR_W = axi_rd_pkg::axi_addr_w;
    localparam int LEN_W  = axi_rd_pkg::axi_len_w;

    logic [ADDR_W-1:0]      addr_q  [OST_DEPTH];
    logic [LEN_W-1:0]       len_q   [OST_DEPTH];
    axi_rd_pkg::axi_burst_e burst_q [OST_DEPTH];

    // --------------------------------------------------
    // Pattern rules, indexed by slot[2:0]
    // --------------------------------------------------
    function automatic logic [ADDR_W-1:0] base_addr(input logic [2:0] pat);
        case (pat)
            3'd1:    return ADDR_W'('h10);
            3'd2:    return ADDR_W'('h20);
            3'd3:    return ADDR_W'('h30);
            3'd4:    return ADDR_W'('h34);
            3'd5:    return ADDR_W'('h38);
            3'd6:    return ADDR_W'('h40);
            default: return '0;             // Pattern 7 accumulates instead
        endcase
    endfunction

    // Encoded as beats minus one
    function automatic logic [LEN_W-1:0] burst_len(input logic [2:0] pat);
        case (pat)
            3'd1, 3'd2, 3'd5, 3'd6: return LEN_W'(7);
            default:                return LEN_W'(3);
        endcase
    endfunction

    function automatic axi_rd_pkg::axi_burst_e burst_type(input logic [2:0] pat);
        case (pat)
            3'd3, 3'd6: return axi_rd_pkg::burst_fixed;
            3'd4, 3'd5: return axi_rd_pkg::burst_wrap;
            default:    return axi_rd_pkg::burst_incr;
        endcase
    endfunction

    // --------------------------------------------------
    // Entry registers, loaded on fill
    // --------------------------------------------------
    for (genvar s = 0; s < OST_DEPTH; s++) begin : g_entry
        localparam logic [2:0] PAT = 3'(s % 8);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                addr_q[s] <= '0;                // Start point of pattern 7
            end else if (fill_en && (fill_slot == PTR_W'(s))) begin
                if (PAT == 3'd7) begin
                    addr_q[s] <= addr_q[s] + axi_rd_pkg::wrap_step;
                end else begin
                    addr_q[s] <= base_addr(PAT);
                end
            end
        end

        always_ff @(posedge clk) begin
            if (fill_en && (fill_slot == PTR_W'(s))) begin
                len_q[s]   <= burst_len(PAT);
                burst_q[s] <= burst_type(PAT);
            end
        end
    end

    // Entry selected by the issue pointer
    assign arid    = ID_W'(issue_slot);
    assign araddr  = addr_q[issue_slot];
    assign arlen   = len_q[issue_slot];
    assign arburst = burst_q[issue_slot];
    assign arsize  = axi_rd_pkg::size_4_byte;

endmodule

`default_nettype wire

/* rtl/ost_slot_table.sv */
`timescale 1ns/10ps
`default_nettype none

module ost_slot_table #(
    parameter int OST_DEPTH   = 16,
    parameter int MAX_REQ_NUM = 32
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                arready,
    input  logic                                rvalid,
    input  logic                                rlast,
    input  logic [axi_rd_pkg::axi_id_w-1:0]     rid,
    output logic                                arvalid,
    output logic                                fill_en,
    output logic [$clog2(OST_DEPTH)-1:0]        fill_slot,
    output logic [$clog2(OST_DEPTH)-1:0]        issue_slot,
    output logic                                req_finish
);

    localparam int PTR_W = $clog2(OST_DEPTH);
    localparam int ID_W  = axi_rd_pkg::axi_id_w;
    localparam int CNT_W = $clog2(MAX_REQ_NUM + 1);

    axi_rd_pkg::slot_state_e slot_state [OST_DEPTH];

    logic [OST_DEPTH-1:0] free_bits;        // Fill requests
    logic [OST_DEPTH-1:0] pend_bits;        // Issue requests
    logic [OST_DEPTH-1:0] done_bits;        // Release requests
    logic [PTR_W-1:0]     release_slot;
    logic                 release_en;
    logic                 ar_xfer;
    logic                 r_done;
    logic [CNT_W-1:0]     done_cnt;

    // --------------------------------------------------
    // Request vectors and handshakes
    // --------------------------------------------------
    always_comb begin
        for (int s = 0; s < OST_DEPTH; s++) begin
            free_bits[s] = (slot_state[s] == axi_rd_pkg::slot_free);
            pend_bits[s] = (slot_state[s] == axi_rd_pkg::slot_pend_ar);
            done_bits[s] = (slot_state[s] == axi_rd_pkg::slot_done);
        end
    end

    assign fill_en    = free_bits[fill_slot];       // One slot per cycle at most
    assign arvalid    = pend_bits[issue_slot];
    assign release_en = done_bits[release_slot];
    assign ar_xfer    = arvalid && arready;
    assign r_done     = rvalid && rlast;            // rready is always high

    // --------------------------------------------------
    // Slot pointers
    // --------------------------------------------------
    rr_pointer_arbiter #(
        .WIDTH    (OST_DEPTH)
    ) u_fill_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_bits (free_bits),
        .step     (fill_en),
        .pointer  (fill_slot)
    );

    rr_pointer_arbiter #(
        .WIDTH    (OST_DEPTH)
    ) u_issue_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_bits (pend_bits),
        .step     (ar_xfer),          // Held under back-pressure
        .pointer  (issue_slot)
    );

    rr_pointer_arbiter #(
        .WIDTH    (OST_DEPTH)
    ) u_release_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_bits (done_bits),
        .step     (release_en),
        .pointer  (release_slot)
    );

    // --------------------------------------------------
    // Per-slot state machines
    // --------------------------------------------------
    for (genvar s = 0; s < OST_DEPTH; s++) begin : g_slot
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                slot_state[s] <= axi_rd_pkg::slot_free;
            end else begin
                case (slot_state[s])
                    axi_rd_pkg::slot_free: begin
                        if (fill_en && (fill_slot == PTR_W'(s))) begin
                            slot_state[s] <= axi_rd_pkg::slot_pend_ar;
                        end
                    end
                    axi_rd_pkg::slot_pend_ar: begin
                        if (ar_xfer && (issue_slot == PTR_W'(s))) begin
                            slot_state[s] <= axi_rd_pkg::slot_wait_r;
                        end
                    end
                    axi_rd_pkg::slot_wait_r: begin
                        // ARID equals slot index so RID selects the slot
                        if (r_done && (rid == ID_W'(s))) begin
                            slot_state[s] <= axi_rd_pkg::slot_done;
                        end
                    end
                    axi_rd_pkg::slot_done: begin
                        if (release_en && (release_slot == PTR_W'(s))) begin
                            slot_state[s] <= axi_rd_pkg::slot_free;
                        end
                    end
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Completion counter
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_cnt <= '0;
        end else if (r_done && (done_cnt != CNT_W'(MAX_REQ_NUM))) begin
            done_cnt <= done_cnt + 1'b1;        // Saturates at the target
        end
    end

    assign req_finish = (done_cnt == CNT_W'(MAX_REQ_NUM));

endmodule

`default_nettype wire

/* rtl/rr_pointer_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module rr_pointer_arbiter #(
    parameter int WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [WIDTH-1:0]         req_bits,
    input  logic                     step,
    output logic [$clog2(WIDTH)-1:0] pointer
);

    localparam int PTR_W = $clog2(WIDTH);

    logic [PTR_W-1:0] next_ptr;
    logic             move;

    // Leave the current slot when told to or when it no longer requests
    assign move = step || !req_bits[pointer];

    // --------------------------------------------------
    // Next set bit after the pointer, circular
    // --------------------------------------------------
    always_comb begin
        int   idx;
        logic found;
        next_ptr = pointer;                             // Hold if nothing requests
        found    = 1'b0;
        for (int k = 1; k <= WIDTH; k++) begin
            idx = (int'(pointer) + k) % WIDTH;          // k == WIDTH lands back on pointer
            if (!found && req_bits[idx]) begin
                next_ptr = PTR_W'(idx);
                found    = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Pointer register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pointer <= '0;
        end else if (move) begin
            pointer <= next_ptr;
        end
    end

endmodule

`default_nettype wire

/* rtl/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

    // --------------------------------------------------
    // AXI field widths
    // --------------------------------------------------
    localparam int axi_id_w   = 4;      // Also caps the slot count at 16
    localparam int axi_addr_w = 32;
    localparam int axi_len_w  = 8;
    localparam int axi_data_w = 32;     // R data width of the slave

    localparam logic [axi_addr_w-1:0] wrap_step = 32'h20;   // Pattern 7 address step

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    typedef enum logic [2:0] {
        size_1_byte   = 3'd0,
        size_2_byte   = 3'd1,
        size_4_byte   = 3'd2,
        size_8_byte   = 3'd3,
        size_16_byte  = 3'd4,
        size_32_byte  = 3'd5,
        size_64_byte  = 3'd6,
        size_128_byte = 3'd7
    } axi_size_e;

    // Life cycle of one outstanding slot
    typedef enum logic [1:0] {
        slot_free    = 2'd0,    // Empty
        slot_pend_ar = 2'd1,    // Filled, AR not yet accepted
        slot_wait_r  = 2'd2,    // AR accepted, waiting for last beat
        slot_done    = 2'd3     // Burst complete, awaiting release
    } slot_state_e;

endpackage

`default_nettype wire
